//--- analog_if_top.f
+incdir+common
common/ising_pkg.sv
source/spin_synchronizer.sv
analog_tx/analog_tx.sv
analog_rx/analog_rx.sv
source/wb_config_regs.sv
source/analog_if_top.sv
tests/analog_macro_model.sv
tests/analog_if_tb.sv

//--- analog_rx/analog_rx.sv
/*
 * analog receive block
 * takes a spin vector over valid/ready, drives it to the macro
 * with a start pulse and relays the completion pulse
 */
module analog_rx (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             en_i,
    input  logic             spin_valid_i,
    output logic             spin_ready_o,
    input  ising_pkg::spin_t spin_i,
    input  logic             tx_idle_i,
    output ising_pkg::spin_t macro_spin_o,
    output logic             macro_start_o,
    input  logic             macro_finish_i,
    output logic             finish_o,
    output logic             busy_o
);
    import ising_pkg::*;

    rx_state_e state_q;
    rx_state_e state_d;
    logic      handshake;
    spin_t     macro_spin_q;
    logic      start_q;
    logic      finish_q;

    // new vector only when idle, enabled and the tx side is free
    assign spin_ready_o = (state_q == RX_IDLE) & en_i & tx_idle_i;
    assign handshake    = spin_valid_i & spin_ready_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            RX_IDLE: begin
                if (handshake) begin
                    state_d = RX_BUSY;
                end
            end
            RX_BUSY: begin
                if (macro_finish_i) begin
                    state_d = RX_IDLE;
                end
            end
            default: state_d = RX_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= RX_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // start and relayed finish are single cycle pulses
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            start_q  <= 1'b0;
            finish_q <= 1'b0;
        end else begin
            start_q  <= handshake;
            finish_q <= macro_finish_i & (state_q == RX_BUSY);
        end
    end

    // macro inputs stay put until the next accepted vector
    always_ff @(posedge clk_i) begin
        if (handshake) begin
            macro_spin_q <= spin_i;
        end
    end

    assign macro_spin_o  = macro_spin_q;
    assign macro_start_o = start_q;
    assign finish_o      = finish_q;
    assign busy_o        = (state_q == RX_BUSY);

    // the macro only completes a run it was started on
    assert property (@(posedge clk_i) disable iff (reset_i)
        macro_finish_i |-> state_q == RX_BUSY)
        else $error("macro finish while receive side idle");

endmodule

//--- analog_tx/analog_tx.sv
/*
 * analog transmit block
 * brings the macro result into the clock domain and holds it
 * behind valid/ready, keeps the synchronizer depth setting
 */
module analog_tx (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   en_i,
    input  logic                   cfg_we_i,
    input  ising_pkg::sync_depth_t depth_i,
    output ising_pkg::sync_depth_t depth_reg_o,
    input  logic                   finish_i,
    input  ising_pkg::spin_t       spin_i,
    output logic                   spin_valid_o,
    input  logic                   spin_ready_i,
    output ising_pkg::spin_t       spin_o,
    output logic                   idle_o
);
    import ising_pkg::*;

    sync_depth_t depth_q;
    logic        sync_valid;
    spin_t       sync_spin;
    logic        valid_q;
    logic        in_flight_q;
    logic        handshake;
    spin_t       spin_q;

    spin_synchronizer i_spin_sync (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .en_i    (en_i),
        .data_i  (spin_i),
        .depth_i (depth_q),
        .start_i (finish_i),
        .valid_o (sync_valid),
        .data_o  (sync_spin)
    );

    assign handshake = valid_q & spin_ready_i;

    // depth only changes while enabled
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            depth_q <= '1;
        end else if (en_i && cfg_we_i) begin
            depth_q <= depth_i;
        end
    end

    // a new result wins over a handshake in the same cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (sync_valid) begin
            valid_q <= 1'b1;
        end else if (!en_i || handshake) begin
            valid_q <= 1'b0;
        end
    end

    // completion seen but result not yet captured
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            in_flight_q <= 1'b0;
        end else if (!en_i) begin
            in_flight_q <= 1'b0;
        end else if (finish_i) begin
            in_flight_q <= 1'b1;
        end else if (sync_valid) begin
            in_flight_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (sync_valid) begin
            spin_q <= sync_spin;
        end
    end

    assign spin_valid_o = valid_q;
    assign spin_o       = spin_q;
    assign depth_reg_o  = depth_q;

    // not idle from the relayed finish until the result is taken
    assign idle_o = ~(valid_q | in_flight_q | finish_i);

endmodule

//--- common/ising_params.svh
/*
 * build constants for the ising analog interface
 * spin vector size, synchronizer stages, wishbone widths
 */
`ifndef ISING_PARAMS_SVH
`define ISING_PARAMS_SVH

// spins per vector handed to the macro
`define ISING_NUM_SPIN 16

// maximum number of synchronizer stages
`define ISING_SYNC_DEPTH 4

// wishbone word address and data widths
`define ISING_WB_AW 4
`define ISING_WB_DW 32

`endif

//--- common/ising_pkg.sv
/*
 * shared types for the ising analog interface
 * spin and depth vectors, wishbone request/response structs,
 * receive FSM states and the register map
 */
`include "ising_params.svh"

package ising_pkg;

    // one spin vector
    typedef logic [`ISING_NUM_SPIN-1:0] spin_t;

    // value d selects d+1 synchronizer stages
    typedef logic [$clog2(`ISING_SYNC_DEPTH)-1:0] sync_depth_t;

    typedef logic [`ISING_WB_AW-1:0] wb_addr_t;
    typedef logic [`ISING_WB_DW-1:0] wb_data_t;

    // wishbone classic master to slave
    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        wb_addr_t                 adr;
        wb_data_t                 dat;
        logic [`ISING_WB_DW/8-1:0] sel;
    } wb_req_t;

    // wishbone classic slave to master
    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

    typedef enum logic {
        RX_IDLE,
        RX_BUSY
    } rx_state_e;

    // word addresses
    localparam wb_addr_t REG_CTRL   = wb_addr_t'(0);
    localparam wb_addr_t REG_DEPTH  = wb_addr_t'(1);
    localparam wb_addr_t REG_STATUS = wb_addr_t'(2);
    localparam wb_addr_t REG_COUNT  = wb_addr_t'(3);

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the analog interface testbench with verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f analog_if_top.f \
    --top-module analog_if_tb -Mdir "$build_dir" -o analog_if_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$build_dir/analog_if_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "NO ERRORS" "$log_file"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed"
exit 1

//--- source/analog_if_top.sv
/*
 * analog interface top level
 * receive block, transmit block and wishbone register block
 */
module analog_if_top (
    input  logic               clk_i,
    input  logic               reset_i,
    input  ising_pkg::wb_req_t wb_req_i,
    output ising_pkg::wb_rsp_t wb_rsp_o,
    input  logic               spin_in_valid_i,
    output logic               spin_in_ready_o,
    input  ising_pkg::spin_t   spin_in_i,
    output ising_pkg::spin_t   macro_spin_o,
    output logic               macro_start_o,
    input  ising_pkg::spin_t   macro_spin_i,
    input  logic               macro_finish_i,
    output logic               spin_out_valid_o,
    input  logic               spin_out_ready_i,
    output ising_pkg::spin_t   spin_out_o
);
    import ising_pkg::*;

    logic        enable;
    logic        depth_we;
    sync_depth_t depth_value;
    sync_depth_t depth_reg;
    logic        tx_idle;
    logic        rx_busy;
    logic        finish;

    analog_rx i_analog_rx (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .en_i           (enable),
        .spin_valid_i   (spin_in_valid_i),
        .spin_ready_o   (spin_in_ready_o),
        .spin_i         (spin_in_i),
        .tx_idle_i      (tx_idle),
        .macro_spin_o   (macro_spin_o),
        .macro_start_o  (macro_start_o),
        .macro_finish_i (macro_finish_i),
        .finish_o       (finish),
        .busy_o         (rx_busy)
    );

    // result path back to the digital side
    analog_tx i_analog_tx (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .en_i         (enable),
        .cfg_we_i     (depth_we),
        .depth_i      (depth_value),
        .depth_reg_o  (depth_reg),
        .finish_i     (finish),
        .spin_i       (macro_spin_i),
        .spin_valid_o (spin_out_valid_o),
        .spin_ready_i (spin_out_ready_i),
        .spin_o       (spin_out_o),
        .idle_o       (tx_idle)
    );

    wb_config_regs i_wb_config_regs (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .wb_req_i    (wb_req_i),
        .wb_rsp_o    (wb_rsp_o),
        .enable_o    (enable),
        .depth_we_o  (depth_we),
        .depth_o     (depth_value),
        .depth_reg_i (depth_reg),
        .tx_idle_i   (tx_idle),
        .rx_busy_i   (rx_busy),
        .out_valid_i (spin_out_valid_o),
        .out_ready_i (spin_out_ready_i)
    );

endmodule

//--- source/spin_synchronizer.sv
/*
 * spin synchronizer
 * completion pulse runs through a flop chain, depth_i picks the tap,
 * macro spins are sampled while the pulse is in flight
 */
`include "ising_params.svh"

module spin_synchronizer (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   en_i,
    input  ising_pkg::spin_t       data_i,
    input  ising_pkg::sync_depth_t depth_i,
    input  logic                   start_i,
    output logic                   valid_o,
    output ising_pkg::spin_t       data_o
);
    import ising_pkg::*;

    localparam int unsigned num_stages = `ISING_SYNC_DEPTH;

    logic [num_stages-1:0] pulse_q;
    logic                  pending;
    spin_t                 sample_q;

    // pulse entering or travelling down the chain
    assign pending = start_i | (|pulse_q);

    // stage k holds the pulse k+1 cycles after start_i
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pulse_q <= '0;
        end else if (!en_i) begin
            pulse_q <= '0;
        end else begin
            pulse_q <= {pulse_q[num_stages-2:0], start_i};
        end
    end

    // sampling stage, macro output is stable from the finish pulse on
    always_ff @(posedge clk_i) begin
        if (en_i && pending) begin
            sample_q <= data_i;
        end
    end

    assign valid_o = en_i & pulse_q[depth_i];
    assign data_o  = sample_q;

    // only one completion pulse may be in the chain at a time
    assert property (@(posedge clk_i) disable iff (reset_i)
        valid_o |=> !valid_o)
        else $error("synchronizer valid held for two cycles");

endmodule

//--- source/wb_config_regs.sv
/*
 * wishbone classic register block
 * enable, depth write strobe, status flags and result count
 */
module wb_config_regs (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  ising_pkg::wb_req_t     wb_req_i,
    output ising_pkg::wb_rsp_t     wb_rsp_o,
    output logic                   enable_o,
    output logic                   depth_we_o,
    output ising_pkg::sync_depth_t depth_o,
    input  ising_pkg::sync_depth_t depth_reg_i,
    input  logic                   tx_idle_i,
    input  logic                   rx_busy_i,
    input  logic                   out_valid_i,
    input  logic                   out_ready_i
);
    import ising_pkg::*;

    logic        access;
    logic        wr;
    logic        wr_low;
    logic        ack_q;
    logic        enable_q;
    logic        depth_we_q;
    sync_depth_t depth_q;
    wb_data_t    count_q;
    wb_data_t    rdata;
    wb_data_t    rdata_q;

    // one access per strobe, the guard keeps ack to a single cycle
    assign access = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
    assign wr     = access & wb_req_i.we;
    assign wr_low = wr & wb_req_i.sel[0];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            enable_q <= 1'b0;
        end else if (wr_low && wb_req_i.adr == REG_CTRL) begin
            enable_q <= wb_req_i.dat[0];
        end
    end

    // depth itself lives in the tx block
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            depth_we_q <= 1'b0;
        end else begin
            depth_we_q <= wr_low && (wb_req_i.adr == REG_DEPTH);
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_low && wb_req_i.adr == REG_DEPTH) begin
            depth_q <= sync_depth_t'(wb_req_i.dat);
        end
    end

    // completed result handshakes, any write clears
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count_q <= '0;
        end else if (wr && wb_req_i.adr == REG_COUNT) begin
            count_q <= '0;
        end else if (out_valid_i && out_ready_i) begin
            count_q <= count_q + 1'b1;
        end
    end

    always_comb begin
        rdata = '0;
        case (wb_req_i.adr)
            REG_CTRL:   rdata[0] = enable_q;
            REG_DEPTH:  rdata = wb_data_t'(depth_reg_i);
            REG_STATUS: begin
                rdata[0] = tx_idle_i;
                rdata[1] = rx_busy_i;
            end
            REG_COUNT:  rdata = count_q;
            default:    rdata = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (access && !wb_req_i.we) begin
            rdata_q <= rdata;
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rdata_q;
    assign enable_o     = enable_q;
    assign depth_we_o   = depth_we_q;
    assign depth_o      = depth_q;

    // master keeps the cycle open until it sees ack
    assert property (@(posedge clk_i) disable iff (reset_i)
        wb_rsp_o.ack |-> wb_req_i.cyc && wb_req_i.stb)
        else $error("wishbone ack without cyc and stb");

endmodule

//--- tests/analog_if_tb.sv
/*
 * testbench for the analog interface top level
 * clock, reset, wishbone tasks, input driver, output ready driver,
 * reference function, comparator and watchdog
 */
module analog_if_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import ising_pkg::*;

    localparam int clk_period    = 40;
    localparam int random_count  = 24;
    localparam int depth_count   = 6;
    localparam int total_vectors = random_count + 4 * depth_count + 2;

    logic    clk;
    logic    reset;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic    spin_in_valid;
    logic    spin_in_ready;
    spin_t   spin_in;
    spin_t   macro_spin;
    logic    macro_start;
    spin_t   macro_result;
    logic    macro_finish;
    logic    spin_out_valid;
    logic    spin_out_ready;
    spin_t   spin_out;

    integer   seed;
    integer   ready_seed;
    spin_t    expected_q[$];
    int       handshakes;
    logic     hold_ready;
    logic     stalled;
    spin_t    stalled_data;
    logic     accepted;
    spin_t    accepted_data;
    wb_data_t rd;

    analog_if_top i_dut (
        .clk_i            (clk),
        .reset_i          (reset),
        .wb_req_i         (wb_req),
        .wb_rsp_o         (wb_rsp),
        .spin_in_valid_i  (spin_in_valid),
        .spin_in_ready_o  (spin_in_ready),
        .spin_in_i        (spin_in),
        .macro_spin_o     (macro_spin),
        .macro_start_o    (macro_start),
        .macro_spin_i     (macro_result),
        .macro_finish_i   (macro_finish),
        .spin_out_valid_o (spin_out_valid),
        .spin_out_ready_i (spin_out_ready),
        .spin_out_o       (spin_out)
    );

    analog_macro_model i_macro (
        .clk_i    (clk),
        .reset_i  (reset),
        .start_i  (macro_start),
        .spin_i   (macro_spin),
        .finish_o (macro_finish),
        .spin_o   (macro_result)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // result expected for one accepted input vector
    function automatic spin_t expected_result(input spin_t v);
        spin_t inv;
        inv = ~v;
        return {inv[$bits(spin_t)-2:0], inv[$bits(spin_t)-1]};
    endfunction

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input wb_data_t got, input wb_data_t exp);
        assert (got == exp) else begin
            $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic wb_access(input logic we, input wb_addr_t addr, input wb_data_t data,
                             output wb_data_t rdata);
        wb_req_t req;
        req     = '0;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = we;
        req.adr = addr;
        req.dat = data;
        req.sel = '1;
        @(posedge clk);
        wb_req <= req;
        @(negedge clk);
        while (!wb_rsp.ack) @(negedge clk);
        rdata = wb_rsp.dat;
        @(posedge clk);
        wb_req <= '0;
    endtask

    task automatic wb_write(input wb_addr_t addr, input wb_data_t data);
        wb_data_t unused;
        wb_access(1'b1, addr, data, unused);
    endtask

    task automatic wb_read(input wb_addr_t addr, output wb_data_t data);
        wb_access(1'b0, addr, '0, data);
    endtask

    // hold valid until the cycle where ready is seen high
    task automatic send_vector(input spin_t v);
        @(posedge clk);
        spin_in_valid <= 1'b1;
        spin_in       <= v;
        @(negedge clk);
        while (!spin_in_ready) @(negedge clk);
        expected_q.push_back(expected_result(v));
        @(posedge clk);
        spin_in_valid <= 1'b0;
    endtask

    task automatic run_vectors(input int count);
        int gap;
        for (int i = 0; i < count; i++) begin
            gap = $unsigned($random(seed)) % 6;
            repeat (gap) @(posedge clk);
            send_vector(spin_t'($random(seed)));
        end
    endtask

    task automatic wait_for_drain();
        @(negedge clk);
        while (expected_q.size() != 0) @(negedge clk);
    endtask

    // output side back-pressure
    initial begin
        ready_seed = 23;
        spin_out_ready <= 1'b0;
        forever begin
            @(posedge clk);
            if (hold_ready) begin
                spin_out_ready <= 1'b0;
            end else begin
                spin_out_ready <= ($random(ready_seed) & 3) != 0;
            end
        end
    end

    // comparator, sampled away from the active edge
    always @(negedge clk) begin
        if (!reset) begin
            assert (!(spin_out_valid && spin_in_ready)) else begin
                $display("input ready while a result is still pending at %0t", $time);
                abort_run();
            end
            // macro start and vector one cycle after an accepted input
            check_value("macro_start_o", wb_data_t'(macro_start), wb_data_t'(accepted));
            if (accepted) begin
                check_value("macro_spin_o", wb_data_t'(macro_spin),
                            wb_data_t'(accepted_data));
            end
            if (stalled && spin_out_valid) begin
                check_value("spin_out_o under back-pressure", wb_data_t'(spin_out),
                            wb_data_t'(stalled_data));
            end
            if (spin_out_valid && spin_out_ready) begin
                assert (expected_q.size() != 0) else begin
                    $display("output handshake without an accepted input at %0t", $time);
                    abort_run();
                end
                check_value("spin_out_o", wb_data_t'(spin_out),
                            wb_data_t'(expected_q.pop_front()));
                handshakes++;
            end
            stalled       = spin_out_valid && !spin_out_ready;
            stalled_data  = spin_out;
            accepted      = spin_in_valid && spin_in_ready;
            accepted_data = spin_in;
        end
    end

    initial begin
        #(total_vectors * 200 * clk_period);
        $display("timeout after %0d cycles with results still missing", total_vectors * 200);
        abort_run();
    end

    initial begin
        seed       = 23;
        handshakes = 0;
        hold_ready = 1'b1;
        stalled    = 1'b0;
        accepted   = 1'b0;
        reset         <= 1'b1;
        wb_req        <= '0;
        spin_in_valid <= 1'b0;
        spin_in       <= '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // reset state
        wb_read(REG_STATUS, rd);
        check_value("wb_rsp.dat STATUS", rd & 32'h3, 32'h1);
        wb_read(REG_DEPTH, rd);
        check_value("wb_rsp.dat DEPTH", rd, 32'h3);
        repeat (8) begin
            @(negedge clk);
            assert (!spin_in_ready) else begin
                $display("spin_in_ready_o high before enable at %0t", $time);
                abort_run();
            end
        end
        wb_write(REG_CTRL, 32'h1);
        @(negedge clk);
        check_value("spin_in_ready_o", wb_data_t'(spin_in_ready), 32'h1);

        // random traffic at reset depth
        hold_ready = 1'b0;
        run_vectors(random_count);
        wait_for_drain();

        for (int d = 0; d < 4; d++) begin
            wb_write(REG_DEPTH, wb_data_t'(d));
            wb_read(REG_DEPTH, rd);
            check_value("wb_rsp.dat DEPTH", rd, wb_data_t'(d));
            run_vectors(depth_count);
            wait_for_drain();
        end

        // result counter
        wb_read(REG_COUNT, rd);
        check_value("wb_rsp.dat COUNT", rd, wb_data_t'(handshakes));
        wb_write(REG_COUNT, 32'h0);
        wb_read(REG_COUNT, rd);
        check_value("wb_rsp.dat COUNT after clear", rd, 32'h0);

        // disable with a result pending
        @(negedge clk);
        hold_ready = 1'b1;
        send_vector(spin_t'($random(seed)));
        @(negedge clk);
        while (!spin_out_valid) @(negedge clk);
        wb_write(REG_CTRL, 32'h0);
        repeat (2) @(negedge clk);
        check_value("spin_out_valid_o after disable", wb_data_t'(spin_out_valid), 32'h0);
        @(posedge clk);
        spin_in_valid <= 1'b1;
        spin_in       <= spin_t'($random(seed));
        repeat (6) begin
            @(negedge clk);
            assert (!spin_in_ready) else begin
                $display("spin_in_ready_o high while disabled at %0t", $time);
                abort_run();
            end
        end
        @(posedge clk);
        spin_in_valid <= 1'b0;
        void'(expected_q.pop_front());
        wb_write(REG_CTRL, 32'h1);
        @(negedge clk);
        hold_ready = 1'b0;
        send_vector(spin_t'($random(seed)));
        wait_for_drain();

        repeat (4) @(posedge clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- tests/analog_macro_model.sv
/*
 * behavioral stand-in for the analog compute macro
 * answers each start after 3 to 10 cycles with the inverted
 * input rotated left by one, held until the next start
 */
module analog_macro_model (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             start_i,
    input  ising_pkg::spin_t spin_i,
    output logic             finish_o,
    output ising_pkg::spin_t spin_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import ising_pkg::*;

    integer      seed;
    int unsigned delay_q;
    logic        active_q;
    spin_t       result_q;
    spin_t       inverted;

    initial seed = 23;

    // model arithmetic, evaluated on the vector present at start
    assign inverted = ~spin_i;

    always @(posedge clk_i) begin
        if (reset_i) begin
            finish_o <= 1'b0;
            spin_o   <= '0;
            active_q <= 1'b0;
            delay_q  <= 0;
            result_q <= '0;
        end else begin
            finish_o <= 1'b0;
            if (start_i) begin
                result_q <= {inverted[$bits(spin_t)-2:0], inverted[$bits(spin_t)-1]};
                delay_q  <= 3 + ($unsigned($random(seed)) % 8);
                active_q <= 1'b1;
            end else if (active_q) begin
                if (delay_q == 1) begin
                    // output settles together with the finish pulse
                    finish_o <= 1'b1;
                    spin_o   <= result_q;
                    active_q <= 1'b0;
                end else begin
                    delay_q <= delay_q - 1;
                end
            end
        end
    end

endmodule
